/* rtl/button_sync.sv */
module button_sync (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_tick,
	input  logic [clock_pkg::NUM_BTNS-1:0] i_btn,
	output logic [clock_pkg::NUM_BTNS-1:0] o_press
);

	import clock_pkg::*;

	logic [NUM_BTNS-1:0] sync1;
	logic [NUM_BTNS-1:0] sync2;
	logic [NUM_BTNS-1:0] samp_new;	// latest debounce sample
	logic [NUM_BTNS-1:0] samp_old;	// sample one tick before

	// two-flop synchronizer on the raw levels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
		end else begin
			sync1 <= i_btn;
			sync2 <= sync1;
		end
	end

	// ------------------------------------------------------------
	// debounce history and rise detect
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_new <= '0;
			samp_old <= '0;
			o_press  <= '0;
		end else begin
			o_press <= '0;
			if (i_tick) begin
				samp_old <= samp_new;
				samp_new <= sync2;
				// both high now, not both high before
				o_press <= sync2 & samp_new & ~samp_old;
			end
		end
	end

	a_press_short : assert property (
		@(posedge clk) disable iff (!rst_n)
		(o_press != '0) |=> ((o_press & $past(o_press)) == '0)
	);

endmodule

/* rtl/clock_pkg.sv */
package clock_pkg;

	// ------------------------------------------------------------
	// widths with a meaning
	// ------------------------------------------------------------
	typedef logic [6:0] field_t;	// one time field, 0..99
	typedef logic [3:0] digit_t;	// one decimal digit
	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}, active high
	typedef logic [5:0] digit_en_t;	// active low, bit i is digit i

	// operating modes, stepped by the mode button
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	// selected field, also the digit pair index (digit >> 1)
	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_t;

	// ------------------------------------------------------------
	// display and buttons
	// ------------------------------------------------------------
	localparam int NUM_DIGITS = 6;
	localparam int NUM_BTNS   = 4;

	localparam int BTN_MODE  = 0;	// mode select
	localparam int BTN_POS   = 1;	// field select
	localparam int BTN_INC   = 2;	// count up selected field
	localparam int BTN_ALARM = 3;	// arm / disarm alarm

	// ------------------------------------------------------------
	// field limits
	// ------------------------------------------------------------
	localparam field_t SEC_MAX = 7'd59;
	localparam field_t MIN_MAX = 7'd59;
	localparam field_t HR_MAX  = 7'd23;	// 24-hour form

endpackage

/* rtl/digital_clock_top.sv */
module digital_clock_top #(
	parameter int TICKS_PER_SEC = 50_000_000,
	parameter int DEBOUNCE_DIV  = 500_000,
	parameter int SCAN_DIV      = 5000,
	parameter int BLINK_DIV     = 2500
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [clock_pkg::NUM_BTNS-1:0] i_btn,
	output clock_pkg::seg_t                o_seg,
	output clock_pkg::digit_en_t           o_seg_enb,
	output logic                           o_alarm
);

	import clock_pkg::*;

	logic                sec_tick;
	logic                db_tick;
	logic [NUM_BTNS-1:0] press;
	mode_t               mode;
	pos_t                pos;
	logic                alarm_en;
	field_t              disp_sec;
	field_t              disp_min;
	field_t              disp_hr;

	// ------------------------------------------------------------
	// enable pulses
	// ------------------------------------------------------------
	tick_gen #(.DIV(TICKS_PER_SEC)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(DEBOUNCE_DIV)) u_db_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (db_tick)
	);

	button_sync u_button_sync (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_tick  (db_tick),
		.i_btn   (i_btn),
		.o_press (press)
	);

	mode_ctrl u_mode_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_mode_press  (press[BTN_MODE]),
		.i_pos_press   (press[BTN_POS]),
		.i_alarm_press (press[BTN_ALARM]),
		.o_mode        (mode),
		.o_pos         (pos),
		.o_alarm_en    (alarm_en)
	);

	time_counter u_time_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_inc_press (press[BTN_INC]),
		.i_mode      (mode),
		.i_pos       (pos),
		.i_alarm_en  (alarm_en),
		.o_disp_sec  (disp_sec),
		.o_disp_min  (disp_min),
		.o_disp_hr   (disp_hr),
		.o_alarm     (o_alarm)
	);

	disp_scan #(
		.SCAN_DIV  (SCAN_DIV),
		.BLINK_DIV (BLINK_DIV)
	) u_disp_scan (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_mode    (mode),
		.i_pos     (pos),
		.i_sec     (disp_sec),
		.i_min     (disp_min),
		.i_hr      (disp_hr),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb)
	);

endmodule

/* rtl/disp_scan.sv */
module disp_scan #(
	parameter int SCAN_DIV  = 5000,
	parameter int BLINK_DIV = 2500
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  clock_pkg::mode_t     i_mode,
	input  clock_pkg::pos_t      i_pos,
	input  clock_pkg::field_t    i_sec,
	input  clock_pkg::field_t    i_min,
	input  clock_pkg::field_t    i_hr,
	output clock_pkg::seg_t      o_seg,
	output clock_pkg::digit_en_t o_seg_enb
);

	import clock_pkg::*;

	localparam int BLINK_W = (BLINK_DIV > 1) ? $clog2(BLINK_DIV) : 1;

	logic               scan_tick;
	logic [2:0]         idx;	// current digit, 0..5
	logic [BLINK_W-1:0] blink_cnt;
	logic               blink_on;	// high = show, low = blank selected pair
	digit_t             cur_digit;
	logic               blank;

	function automatic digit_t ones_of(input field_t v);
		return digit_t'(v % 7'd10);
	endfunction

	function automatic digit_t tens_of(input field_t v);
		return digit_t'(v / 7'd10);
	endfunction

	// normal 0..9 table, a..g msb first
	function automatic seg_t seg_of(input digit_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

	tick_gen #(
		.DIV (SCAN_DIV)
	) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// ------------------------------------------------------------
	// digit index and blink phase
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= '0;
			blink_cnt <= '0;
			blink_on  <= 1'b1;
		end else if (scan_tick) begin
			idx <= (idx == 3'(NUM_DIGITS - 1)) ? 3'd0 : idx + 3'd1;
			if (blink_cnt == BLINK_W'(BLINK_DIV - 1)) begin
				blink_cnt <= '0;
				blink_on  <= ~blink_on;
			end else begin
				blink_cnt <= blink_cnt + 1'b1;
			end
		end
	end

	// ones on even digits, tens on odd
	always_comb begin
		case (idx)
			3'd0:    cur_digit = ones_of(i_sec);
			3'd1:    cur_digit = tens_of(i_sec);
			3'd2:    cur_digit = ones_of(i_min);
			3'd3:    cur_digit = tens_of(i_min);
			3'd4:    cur_digit = ones_of(i_hr);
			default: cur_digit = tens_of(i_hr);
		endcase
	end

	// idx[2:1] is the pair, same order as pos_t
	assign blank = (i_mode == MODE_SETUP || i_mode == MODE_ALARM) &&
		!blink_on && (idx[2:1] == i_pos);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg_enb <= ~digit_en_t'(1);	// digit 0 on
			o_seg     <= seg_of(4'd0);
		end else begin
			o_seg_enb <= ~(digit_en_t'(1) << idx);
			o_seg     <= blank ? 7'b000_0000 : seg_of(cur_digit);
		end
	end

	a_one_digit : assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb)
	);

endmodule

/* rtl/mode_ctrl.sv */
module mode_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_mode_press,
	input  logic              i_pos_press,
	input  logic              i_alarm_press,
	output clock_pkg::mode_t  o_mode,
	output clock_pkg::pos_t   o_pos,
	output logic              o_alarm_en
);

	import clock_pkg::*;

	mode_t mode_q;
	mode_t mode_d;
	pos_t  pos_q;
	pos_t  pos_d;
	logic  alarm_en_q;

	// ------------------------------------------------------------
	// mode FSM: clock -> setup -> alarm -> clock
	// ------------------------------------------------------------
	always_comb begin
		mode_d = mode_q;
		if (i_mode_press) begin
			case (mode_q)
				MODE_CLOCK: mode_d = MODE_SETUP;
				MODE_SETUP: mode_d = MODE_ALARM;
				default:    mode_d = MODE_CLOCK;
			endcase
		end
	end

	// field select: sec -> min -> hr -> sec
	always_comb begin
		pos_d = pos_q;
		if (i_pos_press) begin
			case (pos_q)
				POS_SEC: pos_d = POS_MIN;
				POS_MIN: pos_d = POS_HR;
				default: pos_d = POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			alarm_en_q <= 1'b0;
		end else begin
			mode_q <= mode_d;
			pos_q  <= pos_d;
			if (i_alarm_press)
				alarm_en_q <= ~alarm_en_q;	// arm / disarm
		end
	end

	assign o_mode     = mode_q;
	assign o_pos      = pos_q;
	assign o_alarm_en = alarm_en_q;

	a_pos_legal : assert property (
		@(posedge clk) disable iff (!rst_n)
		o_pos inside {POS_SEC, POS_MIN, POS_HR}
	);

endmodule

/* rtl/tick_gen.sv */
module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = $clog2(DIV);

	logic [CNT_W-1:0] cnt;

	// wraps at DIV-1, so one pulse every DIV cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CNT_W'(DIV - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign o_tick = (cnt == CNT_W'(DIV - 1));	// terminal count

	// enable is a pulse, never a level
	a_tick_single : assert property (
		@(posedge clk) disable iff (!rst_n)
		o_tick |=> !o_tick
	);

endmodule

/* rtl/time_counter.sv */
module time_counter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_sec_tick,
	input  logic              i_inc_press,
	input  clock_pkg::mode_t  i_mode,
	input  clock_pkg::pos_t   i_pos,
	input  logic              i_alarm_en,
	output clock_pkg::field_t o_disp_sec,
	output clock_pkg::field_t o_disp_min,
	output clock_pkg::field_t o_disp_hr,
	output logic              o_alarm
);

	import clock_pkg::*;

	field_t sec;	// running time
	field_t min;
	field_t hr;
	field_t al_sec;	// alarm time
	field_t al_min;
	field_t al_hr;
	logic   match;

	// count up with wrap at max, no carry out
	function automatic field_t wrap_inc(input field_t v, input field_t max);
		return (v >= max) ? '0 : field_t'(v + 7'd1);
	endfunction

	// ------------------------------------------------------------
	// running time
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec <= '0;
			min <= '0;
			hr  <= '0;
		end else if (i_mode == MODE_SETUP) begin
			// time frozen, only the selected field steps
			if (i_inc_press) begin
				case (i_pos)
					POS_SEC: sec <= wrap_inc(sec, SEC_MAX);
					POS_MIN: min <= wrap_inc(min, MIN_MAX);
					POS_HR:  hr  <= wrap_inc(hr, HR_MAX);
					default: ;
				endcase
			end
		end else if (i_sec_tick) begin
			sec <= wrap_inc(sec, SEC_MAX);
			if (sec == SEC_MAX) begin
				min <= wrap_inc(min, MIN_MAX);	// ripple into minutes
				if (min == MIN_MAX)
					hr <= wrap_inc(hr, HR_MAX);
			end
		end
	end

	// ------------------------------------------------------------
	// alarm time, set only in alarm mode
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al_sec <= '0;
			al_min <= '0;
			al_hr  <= '0;
		end else if (i_mode == MODE_ALARM && i_inc_press) begin
			case (i_pos)
				POS_SEC: al_sec <= wrap_inc(al_sec, SEC_MAX);
				POS_MIN: al_min <= wrap_inc(al_min, MIN_MAX);
				POS_HR:  al_hr  <= wrap_inc(al_hr, HR_MAX);
				default: ;
			endcase
		end
	end

	assign match = (sec == al_sec) && (min == al_min) && (hr == al_hr);

	// latched on match, cleared only by disarm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en & (o_alarm | match);
	end

	// display shows alarm time while it is being set
	assign o_disp_sec = (i_mode == MODE_ALARM) ? al_sec : sec;
	assign o_disp_min = (i_mode == MODE_ALARM) ? al_min : min;
	assign o_disp_hr  = (i_mode == MODE_ALARM) ? al_hr  : hr;

	a_time_range : assert property (
		@(posedge clk) disable iff (!rst_n)
		(sec <= SEC_MAX) && (min <= MIN_MAX) && (hr <= HR_MAX)
	);

	a_alarm_range : assert property (
		@(posedge clk) disable iff (!rst_n)
		(al_sec <= SEC_MAX) && (al_min <= MIN_MAX) && (al_hr <= HR_MAX)
	);

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_digital_clock \
	-f vlog.f \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "All tests passed" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

/* tb/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------------------------------------
// helpers for reading the display back
// ------------------------------------------------------------
function automatic logic [3:0] seg_to_digit(input logic [6:0] s);
	case (s)
		7'b111_1110: return 4'd0;
		7'b011_0000: return 4'd1;
		7'b110_1101: return 4'd2;
		7'b111_1001: return 4'd3;
		7'b011_0011: return 4'd4;
		7'b101_1011: return 4'd5;
		7'b101_1111: return 4'd6;
		7'b111_0000: return 4'd7;
		7'b111_1111: return 4'd8;
		7'b111_0011: return 4'd9;
		7'b000_0000: return 4'he;	// blank
		default:     return 4'hf;	// not a digit
	endcase
endfunction

// position of the single low enable bit
function automatic int enb_index(input logic [5:0] enb);
	for (int i = 0; i < 6; i++) begin
		if (!enb[i])
			return i;
	end
	return 7;
endfunction

a_reset_state : assert property (@(posedge clk)
	$rose(rst_n) |-> (!o_alarm && o_seg_enb == 6'h3e && seg_to_digit(o_seg) == 4'd0))
	else begin
		errors++;
		$display("mismatch after reset: o_seg_enb=%h o_seg=%h o_alarm=%h",
			o_seg_enb, o_seg, o_alarm);
	end

a_one_low : assert property (@(posedge clk) disable iff (!rst_n)
	$onehot(~o_seg_enb))
	else begin
		errors++;
		$display("mismatch o_seg_enb: got %h, expected exactly one low bit", o_seg_enb);
	end

// next enabled digit is the one after the last
a_scan_order : assert property (@(posedge clk) disable iff (!rst_n)
	(o_seg_enb != $past(o_seg_enb)) |->
	(enb_index(o_seg_enb) == (enb_index($past(o_seg_enb)) + 1) % 6))
	else begin
		errors++;
		$display("mismatch o_seg_enb: got %h after %h", o_seg_enb, $past(o_seg_enb));
	end

a_digit_value : assert property (@(posedge clk) disable iff (!rst_n || busy)
	(seg_to_digit(o_seg) == m_digs_q[4*enb_index(o_seg_enb) +: 4]) ||
	(o_seg == 7'd0 && m_blinkable_q && enb_index(o_seg_enb) / 2 == m_pos_q))
	else begin
		errors++;
		$display("mismatch o_seg: got %h, expected digit %h at position %0d",
			o_seg, m_digs_q[4*enb_index(o_seg_enb) +: 4], enb_index(o_seg_enb));
	end

// ------------------------------------------------------------
// alarm output
// ------------------------------------------------------------
a_alarm_rise : assert property (@(posedge clk) disable iff (!rst_n || busy)
	(m_alarm_en && $past(m_match, 2)) |-> o_alarm)
	else begin
		errors++;
		$display("alarm did not go high at the alarm time");
	end

a_alarm_hold : assert property (@(posedge clk) disable iff (!rst_n || busy)
	(o_alarm && m_alarm_en) |=> o_alarm)
	else begin
		errors++;
		$display("alarm dropped while still armed");
	end

a_alarm_off : assert property (@(posedge clk) disable iff (!rst_n || busy)
	!m_alarm_en |-> !o_alarm)
	else begin
		errors++;
		$display("mismatch o_alarm: got %h, expected 0", o_alarm);
	end

`endif

/* tb/tb_digital_clock.sv */
module tb_digital_clock;

	import clock_pkg::*;

	localparam int TPS       = 200;
	localparam int DB_DIV    = 4;
	localparam int TEST_SECS = 330;	// all waits and presses, rounded up
	localparam longint WATCHDOG = longint'(TEST_SECS + 20) * TPS * 100;

	logic                clk = 1'b0;
	logic                rst_n;
	logic [NUM_BTNS-1:0] i_btn;
	seg_t                o_seg;
	digit_en_t           o_seg_enb;
	logic                o_alarm;

	int          errors;
	int          cyc;
	logic        busy;	// model and DUT disagree during a press
	int          blank_seen;
	int          shown_seen;

	// reference model
	int          m_sec;
	int          m_min;
	int          m_hr;
	int          m_al_sec;
	int          m_al_min;
	int          m_al_hr;
	mode_t       m_mode;
	int          m_pos;
	logic        m_alarm_en;
	logic        m_match;
	logic [23:0] m_digs;
	logic [23:0] m_digs_q;
	logic        m_blinkable_q;
	int          m_pos_q;

	digital_clock_top #(
		.TICKS_PER_SEC (TPS),
		.DEBOUNCE_DIV  (DB_DIV),
		.SCAN_DIV      (2),
		.BLINK_DIV     (8)
	) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_btn     (i_btn),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb),
		.o_alarm   (o_alarm)
	);

	always #50 clk = ~clk;

	function automatic int step_field(input int v, input int max);
		return (v >= max) ? 0 : v + 1;
	endfunction

	// ------------------------------------------------------------
	// model time, one step per second unless in setup
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			cyc   <= 0;
			m_sec <= 0;
			m_min <= 0;
			m_hr  <= 0;
		end else begin
			cyc <= cyc + 1;
			if ((cyc + 1) % TPS == 0 && m_mode != MODE_SETUP) begin
				m_sec <= step_field(m_sec, 59);
				if (m_sec == 59) begin
					m_min <= step_field(m_min, 59);
					if (m_min == 59)
						m_hr <= step_field(m_hr, 23);
				end
			end
		end
	end

	always_comb begin
		int s;
		int m;
		int h;
		s = (m_mode == MODE_ALARM) ? m_al_sec : m_sec;
		m = (m_mode == MODE_ALARM) ? m_al_min : m_min;
		h = (m_mode == MODE_ALARM) ? m_al_hr : m_hr;
		m_digs = {4'(h / 10), 4'(h % 10), 4'(m / 10), 4'(m % 10),
			4'(s / 10), 4'(s % 10)};
		m_match = (m_sec == m_al_sec) && (m_min == m_al_min) && (m_hr == m_al_hr);
	end

	// display lags the fields by one register
	always @(posedge clk) begin
		m_digs_q      <= m_digs;
		m_blinkable_q <= (m_mode != MODE_CLOCK);
		m_pos_q       <= m_pos;
		if (!rst_n) begin
			blank_seen <= 0;
			shown_seen <= 0;
		end else if (!busy && m_mode == MODE_SETUP &&
			enb_index(o_seg_enb) / 2 == m_pos_q) begin
			if (o_seg == 7'd0)
				blank_seen <= blank_seen + 1;
			else
				shown_seen <= shown_seen + 1;
		end
	end

	`include "tb_checks.svh"

	task automatic wait_secs(input int n);
		repeat (n * TPS) @(negedge clk);
	endtask

	// press away from second ticks, then update the model
	task automatic press_button(input int b);
		busy = 1'b1;
		while (cyc % TPS != 10)
			@(negedge clk);
		i_btn[b] = 1'b1;
		repeat (6 * DB_DIV) @(negedge clk);
		i_btn[b] = 1'b0;
		repeat (6 * DB_DIV) @(negedge clk);
		case (b)
			BTN_MODE: begin
				case (m_mode)
					MODE_CLOCK: m_mode = MODE_SETUP;
					MODE_SETUP: m_mode = MODE_ALARM;
					default:    m_mode = MODE_CLOCK;
				endcase
			end
			BTN_POS:   m_pos = (m_pos + 1) % 3;
			BTN_ALARM: m_alarm_en = !m_alarm_en;
			default: begin
				if (m_mode == MODE_SETUP) begin
					case (m_pos)
						0:       m_sec <= step_field(m_sec, 59);
						1:       m_min <= step_field(m_min, 59);
						default: m_hr <= step_field(m_hr, 23);
					endcase
				end else if (m_mode == MODE_ALARM) begin
					case (m_pos)
						0:       m_al_sec = step_field(m_al_sec, 59);
						1:       m_al_min = step_field(m_al_min, 59);
						default: m_al_hr = step_field(m_al_hr, 23);
					endcase
				end
			end
		endcase
		repeat (2) @(negedge clk);
		busy = 1'b0;
	endtask

	initial begin
		#(WATCHDOG);
		$display("watchdog expired before the tests finished");
		$display("Some tests failed");
		$finish;
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		int n;
		int k;
		int target;
		int waited;
		errors = 0;
		busy = 1'b0;
		i_btn = '0;
		rst_n = 1'b0;
		m_al_sec = 0;
		m_al_min = 0;
		m_al_hr = 0;
		m_mode = MODE_CLOCK;
		m_pos = 0;
		m_alarm_en = 1'b0;
		void'($urandom(24));
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		wait_secs(2);

		press_button(BTN_MODE);	// setup, time frozen
		n = (55 - m_sec + 60) % 60;
		repeat (n) press_button(BTN_INC);
		press_button(BTN_POS);	// minutes
		k = 60 + int'($urandom % 4);	// wraps past 59
		repeat (k) press_button(BTN_INC);
		press_button(BTN_POS);
		press_button(BTN_POS);	// back to seconds
		wait_secs(2);

		press_button(BTN_MODE);	// alarm, time runs on
		press_button(BTN_POS);
		target = m_min + 2 + int'($urandom % 2);
		repeat (target) press_button(BTN_INC);
		press_button(BTN_MODE);	// clock
		wait_secs(1);

		press_button(BTN_ALARM);	// arm
		waited = 0;
		while (!o_alarm && waited < 130 * TPS) begin
			@(negedge clk);
			waited++;
		end
		assert (o_alarm) else begin
			errors++;
			$display("alarm never went high after arming");
		end
		wait_secs(2);
		press_button(BTN_ALARM);	// disarm
		wait_secs(2);

		assert (blank_seen > 0 && shown_seen > 0) else begin
			errors++;
			$display("selected field did not blink in setup mode");
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+tb
rtl/clock_pkg.sv
rtl/tick_gen.sv
rtl/button_sync.sv
rtl/mode_ctrl.sv
rtl/time_counter.sv
rtl/disp_scan.sv
rtl/digital_clock_top.sv
tb/tb_digital_clock.sv
